/* src/pdp8_types_pkg.sv */
package pdp8_types_pkg;

  typedef logic [11:0] word_t;
  typedef logic [11:0] addr_t;

  typedef enum logic [2:0] {AND, TAD, ISZ, DCA, JMS, JMP, IOT, OPR} opcode_e;

  typedef struct packed {
    opcode_e    opcode;
    logic       indirect;
    logic       page;      // 1 selects the current page
    logic [6:0] offset;
  } memref_t;

  typedef struct packed {
    opcode_e opcode;
    logic    group;        // 0 is group 1, 1 is group 2
    logic    cla;
    logic    cll;
    logic    cma;
    logic    cml;
    logic    rar;
    logic    ral;
    logic    rtw;
    logic    iac;
  } operate_t;

  typedef union packed {
    memref_t  mem;
    operate_t opr;
  } instr_u;

  typedef enum logic [1:0] {HALT, FETCH, DEFER, EXEC} major_e;
  typedef enum logic [1:0] {T0, T1, T2, T3} phase_e;

  typedef struct packed {
    major_e major;
    phase_e phase;
    logic   load_ir;
    logic   mem_read;
    logic   mem_write;     // Write slot, qualified by the address unit
    logic   alu_op_en;
  } cpu_ctl_t;

  localparam int    MEM_WORDS    = 4096;
  localparam addr_t AUTOINDEX_LO = 12'o0010;
  localparam addr_t AUTOINDEX_HI = 12'o0017;
  localparam word_t HLT_WORD     = 12'o7402;

endpackage

/* src/pdp8_bus_pkg.sv */
package pdp8_bus_pkg;

  typedef struct packed {
    logic        psel;
    logic        penable;
    logic        pwrite;
    logic [4:0]  paddr;
    logic [31:0] pwdata;
  } apb_req_t;

  typedef struct packed {
    logic [31:0] prdata;
    logic        pready;
    logic        pslverr;
  } apb_rsp_t;

  typedef struct packed {
    logic                  valid;    // Memory deposit or examine
    logic                  write;
    logic                  load_pc;
    logic                  load_ac;
    logic                  link;     // Link value for load_ac
    pdp8_types_pkg::addr_t addr;
    pdp8_types_pkg::word_t data;
  } panel_req_t;

  localparam logic [4:0] REG_CTRL   = 5'h00;
  localparam logic [4:0] REG_STATUS = 5'h04;
  localparam logic [4:0] REG_PC     = 5'h08;
  localparam logic [4:0] REG_AC     = 5'h0C;
  localparam logic [4:0] REG_ADDR   = 5'h10;
  localparam logic [4:0] REG_DATA   = 5'h14;

endpackage

/* src/major_state_fsm.sv */
module major_state_fsm (
  input  logic                     clk,
  input  logic                     reset,
  input  logic                     start,
  input  logic                     stop,
  input  logic                     cycle_end,
  input  pdp8_types_pkg::phase_e   phase,
  input  pdp8_types_pkg::instr_u   ir,
  output pdp8_types_pkg::cpu_ctl_t ctl,
  output logic                     running
);
  import pdp8_types_pkg::*;

  major_e  major;
  major_e  after;
  logic    stop_pend;
  opcode_e op;
  logic    mem_ref;

  assign op      = ir.mem.opcode;
  assign mem_ref = op <= JMP;
  assign running = major != HALT;

  always_comb begin
    case (major)
      FETCH: begin
        if (mem_ref && ir.mem.indirect) after = DEFER;
        else if (mem_ref && op != JMP) after = EXEC;
        else after = FETCH;
      end
      DEFER:   after = (op == JMP) ? FETCH : EXEC;
      default: after = FETCH;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      major     <= HALT;
      stop_pend <= 1'b0;
    end else if (major == HALT) begin
      stop_pend <= 1'b0;
      if (start) major <= FETCH;
    end else begin
      if (stop) stop_pend <= 1'b1;
      if (cycle_end) begin
        // Halt only at an instruction boundary
        if (after == FETCH && (ir == HLT_WORD || stop_pend || stop)) major <= HALT;
        else major <= after;
      end
    end
  end

  always_comb begin
    ctl.major     = major;
    ctl.phase     = phase;
    ctl.load_ir   = major == FETCH && phase == T1;
    ctl.mem_read  = running && phase == T0;
    ctl.mem_write = phase == T2 &&
                    (major == DEFER || (major == EXEC && op inside {ISZ, DCA, JMS}));
    ctl.alu_op_en = phase == T2 &&
                    ((major == EXEC && op inside {AND, TAD, DCA}) ||
                     (major == FETCH && op == OPR));
  end

endmodule

/* src/phase_timer.sv */
module phase_timer (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   running,
  output pdp8_types_pkg::phase_e phase,
  output logic                   cycle_end
);
  import pdp8_types_pkg::*;

  always_ff @(posedge clk) begin
    if (reset) begin
      phase <= T0;
    end else if (!running) begin
      phase <= T0;                        // Held so each start begins in T0
    end else begin
      phase <= phase_e'(phase + 2'd1);    // Wraps after T3
    end
  end

  assign cycle_end = running && phase == T3;

endmodule

/* src/mem_addr_unit.sv */
module mem_addr_unit (
  input  logic                     clk,
  input  logic                     reset,
  input  pdp8_types_pkg::cpu_ctl_t ctl,
  input  pdp8_types_pkg::word_t    ac,
  input  pdp8_bus_pkg::panel_req_t panel,
  input  pdp8_types_pkg::word_t    mem_rdata,
  output pdp8_types_pkg::addr_t    mem_addr,
  output pdp8_types_pkg::word_t    mem_wdata,
  output logic                     mem_we,
  output pdp8_types_pkg::instr_u   ir,
  output pdp8_types_pkg::word_t    mdout,
  output pdp8_types_pkg::addr_t    pc,
  output pdp8_types_pkg::word_t    panel_rdata
);
  import pdp8_types_pkg::*;

  addr_t   ma;
  addr_t   ea;
  addr_t   ptr;
  word_t   incr;
  opcode_e op;
  logic    halted;
  logic    autoindex;
  logic    rd_q;

  assign halted    = ctl.major == HALT;
  assign op        = ir.mem.opcode;
  assign ea        = {ir.mem.page ? ma[11:7] : 5'b0, ir.mem.offset};  // ma still holds fetch addr
  assign autoindex = ma >= AUTOINDEX_LO && ma <= AUTOINDEX_HI;
  assign incr      = mdout + 12'd1;
  assign ptr       = autoindex ? incr : mdout;

  // Panel access borrows the memory port while halted
  assign mem_addr  = (halted && panel.valid) ? panel.addr : ma;
  assign mem_we    = (halted && panel.valid && panel.write) ||
                     (ctl.mem_write && (ctl.major == EXEC || autoindex));
  assign panel_rdata = mdout;

  always_comb begin
    if (halted) mem_wdata = panel.data;
    else if (ctl.major == EXEC && op == DCA) mem_wdata = ac;
    else if (ctl.major == EXEC && op == JMS) mem_wdata = pc;    // Return address
    else mem_wdata = incr;                                      // ISZ and autoindex
  end

  always_ff @(posedge clk) begin
    if (rd_q) mdout <= mem_rdata;
    if (ctl.load_ir) ir <= mem_rdata;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      pc   <= '0;
      ma   <= '0;
      rd_q <= 1'b0;
    end else begin
      rd_q <= ctl.mem_read || (halted && panel.valid && !panel.write);
      if (halted) begin
        if (panel.load_pc) begin
          pc <= panel.data;
          ma <= panel.data;
        end
      end else if (ctl.phase == T2) begin
        if (ctl.major == FETCH) pc <= pc + 12'd1;
        else if (ctl.major == EXEC && op == ISZ && mdout == 12'o7777) pc <= pc + 12'd1;
      end else if (ctl.phase == T3) begin
        case (ctl.major)
          FETCH: begin
            if (op <= JMP) begin
              ma <= ea;
              if (op == JMP && !ir.mem.indirect) pc <= ea;
            end else begin
              ma <= pc;
            end
          end
          DEFER: begin
            ma <= ptr;
            if (op == JMP) pc <= ptr;
          end
          default: begin
            if (op == JMS) begin
              pc <= ma + 12'd1;           // Body starts after the link word
              ma <= ma + 12'd1;
            end else begin
              ma <= pc;
            end
          end
        endcase
      end
    end
  end

endmodule

/* src/core_memory.sv */
module core_memory #(
  parameter int depth = pdp8_types_pkg::MEM_WORDS
) (
  input  logic                  clk,
  input  pdp8_types_pkg::addr_t addr,
  input  pdp8_types_pkg::word_t wdata,
  input  logic                  we,
  output pdp8_types_pkg::word_t rdata
);
  import pdp8_types_pkg::*;

  word_t mem [depth];

  always_ff @(posedge clk) begin
    if (we) mem[addr] <= wdata;
    rdata <= mem[addr];                  // Read-first
  end

endmodule

/* src/accumulator_unit.sv */
module accumulator_unit (
  input  logic                     clk,
  input  logic                     reset,
  input  pdp8_types_pkg::cpu_ctl_t ctl,
  input  pdp8_types_pkg::instr_u   ir,
  input  pdp8_types_pkg::word_t    mdout,
  input  pdp8_bus_pkg::panel_req_t panel,
  output pdp8_types_pkg::word_t    ac,
  output logic                     link
);
  import pdp8_types_pkg::*;

  word_t       a1;
  logic        l1;
  logic [12:0] g1;
  logic [12:0] sum;

  assign sum = {1'b0, ac} + {1'b0, mdout};

  // Group 1 in the machine's order: clear, complement, increment, rotate
  always_comb begin
    a1 = ir.opr.cla ? '0 : ac;
    l1 = ir.opr.cll ? 1'b0 : link;
    if (ir.opr.cma) a1 = ~a1;
    if (ir.opr.cml) l1 = ~l1;
    g1 = {l1, a1} + {12'd0, ir.opr.iac};  // Carry out of AC lands in link
    if (ir.opr.rar) g1 = {g1[0], g1[12:1]};
    else if (ir.opr.ral) g1 = {g1[11:0], g1[12]};
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      ac   <= '0;
      link <= 1'b0;
    end else if (ctl.major == HALT && panel.load_ac) begin
      ac   <= panel.data;
      link <= panel.link;
    end else if (ctl.alu_op_en) begin
      case (ir.mem.opcode)
        AND: ac <= ac & mdout;
        TAD: begin
          ac   <= sum[11:0];
          link <= link ^ sum[12];
        end
        DCA: ac <= '0;                    // Store already done this cycle
        OPR: if (!ir.opr.group) {link, ac} <= g1;
        default: ;
      endcase
    end
  end

endmodule

/* src/panel_apb.sv */
module panel_apb (
  input  logic                     clk,
  input  logic                     reset,
  input  pdp8_bus_pkg::apb_req_t   apb,
  input  logic                     running,
  input  pdp8_types_pkg::addr_t    pc,
  input  pdp8_types_pkg::word_t    ac,
  input  logic                     link,
  input  pdp8_types_pkg::word_t    panel_rdata,
  output pdp8_bus_pkg::apb_rsp_t   rsp,
  output logic                     start,
  output logic                     stop,
  output pdp8_bus_pkg::panel_req_t panel
);
  import pdp8_types_pkg::*;
  import pdp8_bus_pkg::*;

  addr_t      addr_reg;
  logic [1:0] wait_cnt;
  logic       access;
  logic       is_ctrl, is_status, is_pc, is_ac, is_addr, is_data;
  logic       err, mem_acc, done, reg_wr;

  assign access    = apb.psel && apb.penable;
  assign is_ctrl   = apb.paddr == REG_CTRL;
  assign is_status = apb.paddr == REG_STATUS;
  assign is_pc     = apb.paddr == REG_PC;
  assign is_ac     = apb.paddr == REG_AC;
  assign is_addr   = apb.paddr == REG_ADDR;
  assign is_data   = apb.paddr == REG_DATA;

  assign err = !(is_ctrl || is_status || is_pc || is_ac || is_addr || is_data) ||
               (running && (is_data || (apb.pwrite && (is_pc || is_ac || is_addr))));
  assign mem_acc = access && is_data && !err;
  assign done    = wait_cnt == (apb.pwrite ? 2'd1 : 2'd2);  // Examine needs the read turnaround
  assign reg_wr  = access && apb.pwrite && !err;

  always_ff @(posedge clk) begin
    if (reset) begin
      wait_cnt <= '0;
      addr_reg <= '0;
    end else begin
      wait_cnt <= (mem_acc && !done) ? wait_cnt + 2'd1 : 2'd0;
      if (reg_wr && is_addr) addr_reg <= apb.pwdata[11:0];
      else if (mem_acc && done) addr_reg <= addr_reg + 12'd1;
    end
  end

  assign start = reg_wr && is_ctrl && apb.pwdata[0];
  assign stop  = reg_wr && is_ctrl && apb.pwdata[1];

  always_comb begin
    panel.valid   = mem_acc && wait_cnt == 2'd0;  // One request per access
    panel.write   = apb.pwrite;
    panel.load_pc = reg_wr && is_pc;
    panel.load_ac = reg_wr && is_ac;
    panel.link    = apb.pwdata[12];
    panel.addr    = addr_reg;
    panel.data    = apb.pwdata[11:0];
  end

  always_comb begin
    rsp.pready  = access && (!mem_acc || done);
    rsp.pslverr = access && err;
    case (apb.paddr)
      REG_STATUS: rsp.prdata = {31'd0, running};
      REG_PC:     rsp.prdata = {20'd0, pc};
      REG_AC:     rsp.prdata = {19'd0, link, ac};
      REG_ADDR:   rsp.prdata = {20'd0, addr_reg};
      REG_DATA:   rsp.prdata = {20'd0, panel_rdata};
      default:    rsp.prdata = '0;
    endcase
  end

endmodule

/* src/pdp8_top.sv */
module pdp8_top (
  input  logic                   clk,
  input  logic                   reset,
  input  pdp8_bus_pkg::apb_req_t apb,
  output pdp8_bus_pkg::apb_rsp_t rsp
);
  import pdp8_types_pkg::*;
  import pdp8_bus_pkg::*;

  logic       start, stop, running, cycle_end, link, mem_we;
  phase_e     phase;
  cpu_ctl_t   ctl;
  instr_u     ir;
  word_t      ac, mdout, panel_rdata, mem_wdata, mem_rdata;
  addr_t      pc, mem_addr;
  panel_req_t panel;

  panel_apb panel_apb_inst (
    .clk(clk), .reset(reset), .apb(apb), .running(running), .pc(pc), .ac(ac),
    .link(link), .panel_rdata(panel_rdata), .rsp(rsp), .start(start), .stop(stop),
    .panel(panel)
  );

  major_state_fsm major_state_fsm_inst (
    .clk(clk), .reset(reset), .start(start), .stop(stop), .cycle_end(cycle_end),
    .phase(phase), .ir(ir), .ctl(ctl), .running(running)
  );

  phase_timer phase_timer_inst (
    .clk(clk), .reset(reset), .running(running), .phase(phase), .cycle_end(cycle_end)
  );

  mem_addr_unit mem_addr_unit_inst (
    .clk(clk), .reset(reset), .ctl(ctl), .ac(ac), .panel(panel), .mem_rdata(mem_rdata),
    .mem_addr(mem_addr), .mem_wdata(mem_wdata), .mem_we(mem_we), .ir(ir), .mdout(mdout),
    .pc(pc), .panel_rdata(panel_rdata)
  );

  accumulator_unit accumulator_unit_inst (
    .clk(clk), .reset(reset), .ctl(ctl), .ir(ir), .mdout(mdout), .panel(panel),
    .ac(ac), .link(link)
  );

  core_memory #(.depth(MEM_WORDS)) core_memory_inst (
    .clk(clk), .addr(mem_addr), .wdata(mem_wdata), .we(mem_we), .rdata(mem_rdata)
  );

endmodule

/* verification/pdp8_assert.sv */
module pdp8_assert (
  input logic                     clk,
  input logic                     reset,
  input pdp8_bus_pkg::apb_req_t   apb,
  input pdp8_bus_pkg::apb_rsp_t   rsp,
  input pdp8_types_pkg::cpu_ctl_t ctl,
  input pdp8_bus_pkg::panel_req_t panel,
  input logic                     mem_we,
  input logic                     running
);
  import pdp8_types_pkg::*;
  import pdp8_bus_pkg::*;

  // Deposit answers one cycle into the access, examine two
  assert property (@(posedge clk) disable iff (reset)
    (rsp.pready && apb.paddr == REG_DATA && !running) |->
      (apb.pwrite ? ($past(apb.penable) && !$past(apb.penable, 2))
                  : ($past(apb.penable, 2) && !$past(apb.penable, 3))))
    else $error("panel memory access finished at the wrong cycle");

  assert property (@(posedge clk) disable iff (reset)
    (mem_we && ctl.major == HALT) |-> (panel.valid && panel.write))
    else $error("memory write while halted without a panel deposit");

  // A new major cycle always opens in T0
  assert property (@(posedge clk) disable iff (reset)
    (running && ctl.major != $past(ctl.major)) |-> (ctl.phase == T0))
    else $error("major cycle did not start in T0");

endmodule

bind pdp8_top pdp8_assert pdp8_assert_inst (
  .clk(clk), .reset(reset), .apb(apb), .rsp(rsp), .ctl(ctl), .panel(panel),
  .mem_we(mem_we), .running(running)
);

/* verification/pdp8_tb.sv */
module pdp8_tb;
  import pdp8_types_pkg::*;
  import pdp8_bus_pkg::*;

  logic        clk;
  logic        reset;
  apb_req_t    req;
  apb_rsp_t    rsp;
  word_t       ref_mem [MEM_WORDS];     // Model memory image
  word_t       m_ac;
  addr_t       m_pc;
  logic        m_link;
  logic [31:0] seed = 32'h894c_c448;
  int          cycles = 0;
  int          deadline = 1000;
  string       cmp_name [$];
  logic [31:0] cmp_exp [$];
  logic [31:0] cmp_act [$];

  pdp8_top pdp8_top_inst (.clk(clk), .reset(reset), .apb(req), .rsp(rsp));

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  task automatic stop_with_failure();
    $display("Test failures found");
    $fatal(1, "stopping at the first error");
  endtask

  task automatic check(input string name, input logic [31:0] exp, input logic [31:0] act);
    if (act !== exp) begin
      $display("Mismatch %s: expected %h, got %h", name, exp, act);
      stop_with_failure();
    end
  endtask

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles > deadline) begin
      $display("Timeout: the core or the bus did not finish in time");
      stop_with_failure();
    end
  end

  // Compare process
  initial forever begin
    wait (cmp_name.size() != 0);
    check(cmp_name.pop_front(), cmp_exp.pop_front(), cmp_act.pop_front());
  end

  task automatic expect_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
    cmp_name.push_back(name);
    cmp_exp.push_back(exp);
    cmp_act.push_back(act);
  endtask

  task automatic arm_timer(input int n);
    deadline = cycles + 20 * n + 200;
  endtask

  function automatic logic [31:0] rnd(input logic [31:0] n);
    seed = seed * 32'd1664525 + 32'd1013904223;
    return (seed >> 8) % n;
  endfunction

  // Instruction-set model, runs until HLT or max_instr
  function automatic int model_run(input int max_instr);
    word_t       ir;
    addr_t       ea;
    logic [12:0] t;
    int          n;
    for (n = 0; n < max_instr; n++) begin
      ir = ref_mem[m_pc];
      ea = {ir[7] ? m_pc[11:7] : 5'd0, ir[6:0]};
      m_pc = m_pc + 12'd1;
      if (ir[11:9] < 3'd6 && ir[8]) begin
        if (ea >= 12'o10 && ea <= 12'o17) ref_mem[ea] = ref_mem[ea] + 12'd1;
        ea = ref_mem[ea];
      end
      case (ir[11:9])
        3'd0: m_ac = m_ac & ref_mem[ea];
        3'd1: begin
          t = {1'b0, m_ac} + {1'b0, ref_mem[ea]};
          m_ac = t[11:0];
          m_link = m_link ^ t[12];
        end
        3'd2: begin
          ref_mem[ea] = ref_mem[ea] + 12'd1;
          if (ref_mem[ea] == 12'd0) m_pc = m_pc + 12'd1;
        end
        3'd3: begin
          ref_mem[ea] = m_ac;
          m_ac = '0;
        end
        3'd4: begin
          ref_mem[ea] = m_pc;
          m_pc = ea + 12'd1;
        end
        3'd5: m_pc = ea;
        3'd7: begin
          if (ir == HLT_WORD) return n + 1;
          if (!ir[8]) begin
            t = {ir[6] ? 1'b0 : m_link, ir[7] ? 12'd0 : m_ac};
            if (ir[5]) t[11:0] = ~t[11:0];
            if (ir[4]) t[12] = ~t[12];
            t = t + {12'd0, ir[0]};
            if (ir[3]) t = {t[0], t[12:1]};
            else if (ir[2]) t = {t[11:0], t[12]};
            {m_link, m_ac} = t;
          end
        end
        default: ;
      endcase
    end
    return n;
  endfunction

  task automatic apb_access(input logic wr, input logic [4:0] a, input logic [31:0] wd,
                            output logic [31:0] rd, output logic err);
    int waited;
    @(negedge clk);
    req.psel    = 1'b1;
    req.penable = 1'b0;
    req.pwrite  = wr;
    req.paddr   = a;
    req.pwdata  = wd;
    @(negedge clk);
    req.penable = 1'b1;
    waited = 0;
    #5;
    while (!rsp.pready) begin
      @(negedge clk);
      #5;
      waited++;
      if (waited > 16) begin
        $display("APB access never completed");
        stop_with_failure();
      end
    end
    rd  = rsp.prdata;
    err = rsp.pslverr;
    @(negedge clk);
    req.psel    = 1'b0;
    req.penable = 1'b0;
  endtask

  task automatic apb_write(input logic [4:0] a, input logic [31:0] d);
    logic [31:0] rd;
    logic        err;
    apb_access(1'b1, a, d, rd, err);
    expect_eq("pslverr", 32'd0, 32'(err));
  endtask

  task automatic apb_read(input logic [4:0] a, output logic [31:0] rd);
    logic err;
    apb_access(1'b0, a, 32'd0, rd, err);
    expect_eq("pslverr", 32'd0, 32'(err));
  endtask

  task automatic write_ac(input logic l, input word_t a);
    apb_write(REG_AC, {19'd0, l, a});
    m_ac   = a;
    m_link = l;
  endtask

  task automatic load_image(input int lo, input int hi);
    arm_timer(hi - lo + 1);
    apb_write(REG_ADDR, 32'(lo));
    for (int i = lo; i <= hi; i++) apb_write(REG_DATA, {20'd0, ref_mem[i]});
  endtask

  task automatic verify_memory(input int lo, input int hi);
    logic [31:0] rd;
    arm_timer(hi - lo + 1);
    apb_write(REG_ADDR, 32'(lo));
    for (int i = lo; i <= hi; i++) begin
      apb_read(REG_DATA, rd);
      expect_eq($sformatf("mem[%0o]", i), {20'd0, ref_mem[i]}, rd);
    end
  endtask

  task automatic wait_halt();
    logic [31:0] rd;
    rd = 32'd1;
    while (rd[0]) apb_read(REG_STATUS, rd);
  endtask

  // Start at 0200 and compare PC and AC with the model
  task automatic run_program(input int n);
    logic [31:0] rd;
    arm_timer(n);
    apb_write(REG_PC, 32'o200);
    apb_write(REG_CTRL, 32'd1);
    wait_halt();
    apb_read(REG_PC, rd);
    expect_eq("pc", 32'(m_pc), rd);
    apb_read(REG_AC, rd);
    expect_eq("link_ac", 32'({m_link, m_ac}), rd);
  endtask

  initial begin
    addr_t       a;
    word_t       d;
    logic [31:0] rd;
    logic        err;
    int          n;
    int          r;
    reset = 1'b1;
    req   = '0;
    repeat (16) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    // Deposit and examine with ADDR auto-increment
    arm_timer(40);
    for (int i = 0; i < 8; i++) begin
      a = addr_t'(rnd(4096));
      d = word_t'(rnd(4096));
      apb_write(REG_ADDR, {20'd0, a});
      apb_write(REG_DATA, {20'd0, d});
      apb_read(REG_ADDR, rd);
      expect_eq("addr", {20'd0, addr_t'(a + 12'd1)}, rd);
      apb_write(REG_ADDR, {20'd0, a});
      apb_read(REG_DATA, rd);
      expect_eq("data", {20'd0, d}, rd);
      apb_read(REG_ADDR, rd);
      expect_eq("addr", {20'd0, addr_t'(a + 12'd1)}, rd);
    end

    // Straight-line memory-reference programs
    for (int p = 0; p < 4; p++) begin
      for (int i = 0; i < 256; i++) ref_mem[i] = word_t'(rnd(4096));
      for (int i = 0; i < 12; i++) begin
        if (rnd(2) == 0) ref_mem['o200 + i] = {3'(rnd(4)), 2'b00, 7'(rnd(48) + 16)};
        else ref_mem['o200 + i] = {3'(rnd(4)), 2'b01, 7'(rnd(64) + 64)};
      end
      ref_mem[12'o214] = HLT_WORD;
      ref_mem[12'o215] = HLT_WORD;   // Landing spot if the last ISZ skips
      write_ac(1'(rnd(2)), word_t'(rnd(4096)));
      load_image(0, 'o377);
      m_pc = 12'o200;
      n = model_run(1000);
      run_program(n);
      verify_memory(0, 'o377);
    end

    // Indirect through autoindex and ordinary pointers
    for (int i = 0; i < 256; i++) ref_mem[i] = word_t'(rnd(4096));
    ref_mem[12'o10]  = 12'o277;
    ref_mem[12'o11]  = 12'o317;
    ref_mem[12'o250] = 12'o310;
    ref_mem[12'o200] = 12'o1410;
    ref_mem[12'o201] = 12'o1410;
    ref_mem[12'o202] = 12'o1650;
    ref_mem[12'o203] = 12'o3411;
    ref_mem[12'o204] = HLT_WORD;
    write_ac(1'(rnd(2)), word_t'(rnd(4096)));
    load_image(0, 'o377);
    m_pc = 12'o200;
    n = model_run(100);
    run_program(n);
    verify_memory(0, 'o377);

    // JMS with return through JMP I
    for (int i = 0; i < 256; i++) ref_mem[i] = word_t'(rnd(4096));
    ref_mem[12'o200] = 12'o7200;
    ref_mem[12'o201] = 12'o1240;
    ref_mem[12'o202] = 12'o4220;
    ref_mem[12'o203] = HLT_WORD;
    ref_mem[12'o221] = 12'o7001;
    ref_mem[12'o222] = 12'o5620;
    write_ac(1'(rnd(2)), word_t'(rnd(4096)));
    load_image(0, 'o377);
    m_pc = 12'o200;
    n = model_run(100);
    run_program(n);
    verify_memory('o200, 'o240);

    // Group 1 operate combinations
    for (int i = 0; i < 12; i++) begin
      r = int'(rnd(3));
      ref_mem[12'o200] = {4'b1110, 4'(rnd(16)), r == 2, r == 1, 1'b0, 1'(rnd(2))};
      ref_mem[12'o201] = HLT_WORD;
      write_ac(1'(rnd(2)), word_t'(rnd(4096)));
      load_image('o200, 'o201);
      m_pc = 12'o200;
      n = model_run(10);
      run_program(n);
    end

    // Refused accesses while running, then stop at a boundary
    for (int i = 'o200; i < 'o600; i++) ref_mem[i] = 12'o7001;
    ref_mem[12'o600] = HLT_WORD;
    write_ac(1'b0, 12'd0);
    load_image('o200, 'o600);
    arm_timer(300);
    apb_write(REG_PC, 32'o200);
    apb_write(REG_CTRL, 32'd1);
    repeat (rnd(40) + 20) @(negedge clk);
    apb_access(1'b0, REG_DATA, 32'd0, rd, err);
    expect_eq("pslverr", 32'd1, 32'(err));
    apb_access(1'b1, REG_PC, 32'd0, rd, err);
    expect_eq("pslverr", 32'd1, 32'(err));
    apb_write(REG_CTRL, 32'd2);
    wait_halt();
    apb_read(REG_AC, rd);
    m_pc = 12'o200;
    n = model_run(int'(rd[11:0]));
    apb_read(REG_PC, rd);
    expect_eq("pc", 32'(m_pc), rd);

    wait (cmp_name.size() == 0);
    @(negedge clk);
    $display("All tests passed!");
    $finish;
  end

endmodule

/* sources.f */
src/pdp8_types_pkg.sv
src/pdp8_bus_pkg.sv
src/major_state_fsm.sv
src/phase_timer.sv
src/mem_addr_unit.sv
src/core_memory.sv
src/accumulator_unit.sv
src/panel_apb.sv
src/pdp8_top.sv
verification/pdp8_assert.sv
verification/pdp8_tb.sv

/* run.sh */
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert -f sources.f --top-module pdp8_tb -o pdp8_sim
./obj_dir/pdp8_sim
